/* rtl/vga_pattern_gen.sv */
`timescale 1ns/1ns

module vga_pattern_gen (
   input  logic                 clk,
   input  logic                 rst_n,
   input  vga_pkg::vga_pos_t    pos,
   input  logic                 hsync,
   input  logic                 vsync,
   input  vga_pkg::pattern_t    pattern,
   input  vga_pkg::vga_colour_t solid,
   output vga_pkg::vga_pins_t   pins
);

   logic [2:0]           bar;
   vga_pkg::vga_colour_t colour;

   // Bar index from x bits 3..1
   assign bar = pos.x[3:1];

   always_comb begin
      colour = '0;
      case (pattern)
         vga_pkg::pat_solid: begin
            colour = solid;
         end
         vga_pkg::pat_bars: begin
            // White first, black last
            colour.r = {4{~bar[1]}};
            colour.g = {4{~bar[2]}};
            colour.b = {4{~bar[0]}};
         end
         vga_pkg::pat_checker: begin
            // White where x bit 2 and y bit 2 differ
            if (pos.x[2] ^ pos.y[2]) begin
               colour = '1;
            end
         end
         vga_pkg::pat_ramp: begin
            colour.r = pos.x[3:0];
            colour.g = pos.y[3:0];
            colour.b = '0;
         end
         default: begin
            colour = '0;
         end
      endcase
      // Porches and sync stay black
      if (!pos.visible) begin
         colour = '0;
      end
   end

   // Output stage, syncs ride along to keep alignment
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pins.colour <= '0;
         pins.hsync  <= 1'b1;
         pins.vsync  <= 1'b1;
      end else begin
         pins.colour <= colour;
         pins.hsync  <= hsync;
         pins.vsync  <= vsync;
      end
   end

endmodule

/* rtl/vga_pkg.sv */
package vga_pkg;

   // Width of beam counters and coordinates
   localparam int POS_W = 12;

   // One colour sample, 4 bits per channel
   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } vga_colour_t;

   // Connector bundle
   // Syncs are active low
   typedef struct packed {
      vga_colour_t colour;
      logic        hsync;
      logic        vsync;
   } vga_pins_t;

   // Beam position relative to the first visible pixel
   typedef struct packed {
      logic [POS_W-1:0] x;
      logic [POS_W-1:0] y;
      logic             visible;
   } vga_pos_t;

   // Test pattern select
   typedef enum logic [1:0] {
      pat_solid   = 2'd0,  // Solid colour input
      pat_bars    = 2'd1,  // 8 vertical colour bars
      pat_checker = 2'd2,  // Black and white squares
      pat_ramp    = 2'd3   // Red along x, green along y
   } pattern_t;

   // Sticky checker flags
   typedef struct packed {
      logic hs_width;
      logic hs_period;
      logic vs_width;
      logic vs_period;
      logic blank_colour;
   } sync_err_t;

endpackage

/* rtl/vga_subsystem_top.sv */
`timescale 1ns/1ns

module vga_subsystem_top #(
   parameter int H_VIS = 640,
   parameter int H_FP  = 16,
   parameter int H_PW  = 96,
   parameter int H_BP  = 48,
   parameter int V_VIS = 480,
   parameter int V_FP  = 10,
   parameter int V_PW  = 2,
   parameter int V_BP  = 33
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  vga_pkg::pattern_t    pattern,
   input  vga_pkg::vga_colour_t solid,
   input  vga_pkg::vga_pins_t   mon,
   input  logic                 clear,
   output vga_pkg::vga_pins_t   pins,
   output vga_pkg::sync_err_t   err,
   output logic [15:0]          frame_count,
   output logic                 locked
);

   vga_pkg::vga_pos_t pos;
   logic              hsync_raw;
   logic              vsync_raw;

   // Beam counters and syncs
   vga_timing_gen #(
      .H_VIS(H_VIS), .H_FP(H_FP), .H_PW(H_PW), .H_BP(H_BP),
      .V_VIS(V_VIS), .V_FP(V_FP), .V_PW(V_PW), .V_BP(V_BP)
   ) i_vga_timing_gen (
      .clk  (clk),
      .rst_n(rst_n),
      .pos  (pos),
      .hsync(hsync_raw),
      .vsync(vsync_raw)
   );

   // Colour source, drives the connector
   vga_pattern_gen i_vga_pattern_gen (
      .clk    (clk),
      .rst_n  (rst_n),
      .pos    (pos),
      .hsync  (hsync_raw),
      .vsync  (vsync_raw),
      .pattern(pattern),
      .solid  (solid),
      .pins   (pins)
   );

   // Watches the looped-back pins, not the internal bundle
   vga_sync_checker #(
      .H_VIS(H_VIS), .H_FP(H_FP), .H_PW(H_PW), .H_BP(H_BP),
      .V_VIS(V_VIS), .V_FP(V_FP), .V_PW(V_PW), .V_BP(V_BP)
   ) i_vga_sync_checker (
      .clk        (clk),
      .rst_n      (rst_n),
      .mon        (mon),
      .clear      (clear),
      .err        (err),
      .frame_count(frame_count),
      .locked     (locked)
   );

endmodule

/* rtl/vga_sync_checker.sv */
`timescale 1ns/1ns

module vga_sync_checker #(
   parameter int H_VIS = 640,
   parameter int H_FP  = 16,
   parameter int H_PW  = 96,
   parameter int H_BP  = 48,
   parameter int V_VIS = 480,
   parameter int V_FP  = 10,
   parameter int V_PW  = 2,
   parameter int V_BP  = 33
) (
   input  logic               clk,
   input  logic               rst_n,
   input  vga_pkg::vga_pins_t mon,
   input  logic               clear,
   output vga_pkg::sync_err_t err,
   output logic [15:0]        frame_count,
   output logic               locked
);

   localparam int CW = vga_pkg::POS_W;

   // Periods and the count just before the next falling edge
   localparam logic [CW-1:0] H_TOT   = CW'(H_VIS + H_FP + H_PW + H_BP);
   localparam logic [CW-1:0] V_TOT   = CW'(V_VIS + V_FP + V_PW + V_BP);
   localparam logic [CW-1:0] H_LAST  = CW'(H_VIS + H_FP + H_PW + H_BP - 1);
   localparam logic [CW-1:0] V_LAST  = CW'(V_VIS + V_FP + V_PW + V_BP - 1);
   localparam logic [CW-1:0] H_PULSE = CW'(H_PW);
   localparam logic [CW-1:0] V_PULSE = CW'(V_PW);
   // Visible window bounds, measured from the falling edge
   localparam logic [CW-1:0] H_ACT   = CW'(H_PW + H_BP);
   localparam logic [CW-1:0] V_ACT   = CW'(V_PW + V_BP);
   localparam logic [CW-1:0] H_FPS   = CW'(H_PW + H_BP + H_VIS);
   localparam logic [CW-1:0] V_FPS   = CW'(V_PW + V_BP + V_VIS);

   logic               hs_q;
   logic               vs_q;
   logic               hs_fall;
   logic               hs_rise;
   logic               vs_fall;
   logic [CW-1:0]      h_pos;
   logic [CW-1:0]      v_pos;
   logic [CW-1:0]      h_cur;
   logic [CW-1:0]      v_cur;
   logic               h_over;
   logic               v_over;
   logic               h_blank;
   logic               v_blank;
   vga_pkg::sync_err_t err_now;

   // Edge detect against the previous sample
   assign hs_fall = hs_q & ~mon.hsync;
   assign hs_rise = ~hs_q & mon.hsync;
   assign vs_fall = vs_q & ~mon.vsync;

   // Counters saturate one past the period when sync goes missing
   assign h_over = (h_pos >= H_LAST);
   assign v_over = (v_pos >= V_LAST);

   // Index of the current sample within the line
   assign h_cur = hs_fall ? '0 : (h_over ? H_TOT : h_pos + 1'b1);

   // Line within frame, steps on hsync falling edges only
   always_comb begin
      if (vs_fall) begin
         v_cur = '0;
      end else if (hs_fall) begin
         v_cur = v_over ? V_TOT : v_pos + 1'b1;
      end else begin
         v_cur = v_pos;
      end
   end

   // Sync, back porch and front porch regions
   assign h_blank = (h_cur < H_ACT) || (h_cur >= H_FPS);
   assign v_blank = (v_cur < V_ACT) || (v_cur >= V_FPS);

   always_comb begin
      err_now = '0;
      // hsync must rise exactly H_PW counts after falling
      err_now.hs_width  = (hs_rise && (h_cur != H_PULSE)) ||
                          (!mon.hsync && (h_cur >= H_PULSE));
      // Next fall due on count H_TOT, late or early both flagged
      err_now.hs_period = hs_fall ? (h_pos != H_LAST) : h_over;
      // Vertical rules in lines, sampled at line starts
      if (hs_fall) begin
         err_now.vs_width  = mon.vsync ? (v_cur < V_PULSE) : (v_cur >= V_PULSE);
         err_now.vs_period = vs_fall ? (v_pos != V_LAST) : v_over;
      end
      // vsync edge off a line start
      if (vs_fall && !hs_fall) begin
         err_now.vs_period = 1'b1;
      end
      // Anything lit outside the visible window
      err_now.blank_colour = (mon.colour != '0) && (h_blank || v_blank);
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         hs_q  <= 1'b1;
         vs_q  <= 1'b1;
         h_pos <= '0;
         v_pos <= '0;
      end else begin
         hs_q  <= mon.hsync;
         vs_q  <= mon.vsync;
         h_pos <= h_cur;
         v_pos <= v_cur;
      end
   end

   // Lock on first frame start, rules apply from the next sample
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         locked      <= 1'b0;
         frame_count <= '0;
         err         <= '0;
      end else begin
         if (vs_fall) begin
            locked <= 1'b1;
            if (locked) begin
               frame_count <= frame_count + 1'b1;
            end
         end
         // clear beats a new error in the same cycle
         if (clear) begin
            err <= '0;
         end else if (locked) begin
            err <= err | err_now;
         end
      end
   end

endmodule

/* rtl/vga_timing_gen.sv */
`timescale 1ns/1ns

module vga_timing_gen #(
   // Line timing in pixel clocks
   parameter int H_VIS = 640,
   parameter int H_FP  = 16,
   parameter int H_PW  = 96,
   parameter int H_BP  = 48,
   // Frame timing in lines
   parameter int V_VIS = 480,
   parameter int V_FP  = 10,
   parameter int V_PW  = 2,
   parameter int V_BP  = 33
) (
   input  logic              clk,
   input  logic              rst_n,
   output vga_pkg::vga_pos_t pos,
   output logic              hsync,
   output logic              vsync
);

   localparam int CW = vga_pkg::POS_W;

   // Last count of a line and of a frame
   localparam logic [CW-1:0] H_LAST  = CW'(H_VIS + H_FP + H_PW + H_BP - 1);
   localparam logic [CW-1:0] V_LAST  = CW'(V_VIS + V_FP + V_PW + V_BP - 1);
   // Sync pulse lengths
   localparam logic [CW-1:0] H_SYNC  = CW'(H_PW);
   localparam logic [CW-1:0] V_SYNC  = CW'(V_PW);
   // Visible window starts after sync and back porch
   localparam logic [CW-1:0] H_START = CW'(H_PW + H_BP);
   localparam logic [CW-1:0] V_START = CW'(V_PW + V_BP);
   localparam logic [CW-1:0] H_END   = CW'(H_PW + H_BP + H_VIS);
   localparam logic [CW-1:0] V_END   = CW'(V_PW + V_BP + V_VIS);

   logic [CW-1:0] h_cnt;
   logic [CW-1:0] v_cnt;
   logic          h_last;
   logic          v_last;
   logic          h_vis;
   logic          v_vis;

   assign h_last = (h_cnt == H_LAST);
   assign v_last = (v_cnt == V_LAST);

   // Count 0 is the sync falling edge
   assign h_vis = (h_cnt >= H_START) && (h_cnt < H_END);
   assign v_vis = (v_cnt >= V_START) && (v_cnt < V_END);

   // Pixel counter, steps the line counter on wrap
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else if (h_last) begin
         h_cnt <= '0;
         v_cnt <= v_last ? '0 : v_cnt + 1'b1;
      end else begin
         h_cnt <= h_cnt + 1'b1;
      end
   end

   // Registered outputs, one cycle behind the counters
   // vsync changes with the hsync falling edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pos   <= '0;
         hsync <= 1'b1;
         vsync <= 1'b1;
      end else begin
         // Offsets wrap outside the window, visible masks them
         pos.x       <= h_cnt - H_START;
         pos.y       <= v_cnt - V_START;
         pos.visible <= h_vis && v_vis;
         hsync       <= (h_cnt >= H_SYNC);
         vsync       <= (v_cnt >= V_SYNC);
      end
   end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the VGA subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module tb_vga_subsystem -o sim_vga
# Status comes from grep, so a missing pass line fails the script
./obj_dir/sim_vga | tee /dev/stderr | grep "TESTBENCH PASSED" > /dev/null

/* sources.f */
rtl/vga_pkg.sv
rtl/vga_timing_gen.sv
rtl/vga_pattern_gen.sv
rtl/vga_sync_checker.sv
rtl/vga_subsystem_top.sv
tests/tb_vga_subsystem.sv

/* tests/tb_vga_subsystem.sv */
`timescale 1ns/1ns

module tb_vga_subsystem;

   // Tiny mode of 24 clocks per line and 13 lines per frame
   localparam int H_VIS = 16;
   localparam int H_FP  = 2;
   localparam int H_PW  = 3;
   localparam int H_BP  = 3;
   localparam int V_VIS = 8;
   localparam int V_FP  = 1;
   localparam int V_PW  = 2;
   localparam int V_BP  = 2;
   localparam int H_TOT = H_VIS + H_FP + H_PW + H_BP;
   localparam int V_TOT = V_VIS + V_FP + V_PW + V_BP;
   localparam int MAX_STEPS = 32;

   // Bars from left to right are white yellow cyan green magenta red blue black
   localparam logic [95:0] BAR_TABLE = {12'h000, 12'h00f, 12'hf00, 12'hf0f,
                                        12'h0f0, 12'h0ff, 12'hff0, 12'hfff};

   logic                 clk;
   logic                 rst_n;
   vga_pkg::pattern_t    pattern;
   vga_pkg::vga_colour_t solid;
   vga_pkg::vga_pins_t   mon;
   logic                 clear;
   vga_pkg::vga_pins_t   pins;
   vga_pkg::sync_err_t   err;
   logic [15:0]          frame_count;
   logic                 locked;

   // One entry per trace step
   int st_pattern [MAX_STEPS];
   int st_solid   [MAX_STEPS];
   int st_fault   [MAX_STEPS];
   int st_frames  [MAX_STEPS];
   int st_err     [MAX_STEPS];
   int st_clear   [MAX_STEPS];
   int n_steps;

   // Beam position as seen on the pins
   int          h_idx;
   int          v_idx;
   int          h_low;
   logic        h_seen;
   logic        v_seen;
   logic        hs_prev;
   logic        vs_prev;
   // Loopback state and expected checker outputs
   logic        mon_vs_prev;
   int          fault;
   int          frames_seen;
   logic        err_live;
   logic [4:0]  exp_err;
   logic        exp_locked;
   logic [15:0] exp_fc;
   int          cycles;
   int          limit;
   int          seed;

   vga_subsystem_top #(
      .H_VIS(H_VIS), .H_FP(H_FP), .H_PW(H_PW), .H_BP(H_BP),
      .V_VIS(V_VIS), .V_FP(V_FP), .V_PW(V_PW), .V_BP(V_BP)
   ) i_vga_subsystem_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .pattern    (pattern),
      .solid      (solid),
      .mon        (mon),
      .clear      (clear),
      .pins       (pins),
      .err        (err),
      .frame_count(frame_count),
      .locked     (locked)
   );

   always #10 clk = ~clk;

   task automatic abort_run();
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
      $display("[FAIL] t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      abort_run();
   endtask

   task automatic report_error(string msg);
      $display("ERROR at t=%0t: %s", $time, msg);
      abort_run();
   endtask

   // Pixel colour for visible position x, y under the current inputs
   function automatic logic [11:0] expected_colour(int x, int y);
      logic [11:0] c;
      case (pattern)
         vga_pkg::pat_solid:   c = solid;
         vga_pkg::pat_bars:    c = BAR_TABLE[(x / 2) * 12 +: 12];
         vga_pkg::pat_checker: c = (((x / 4) % 2) != ((y / 4) % 2)) ? 12'hfff : 12'h000;
         vga_pkg::pat_ramp:    c = {4'(x % 16), 4'(y % 16), 4'h0};
         default:              c = 12'h000;
      endcase
      return c;
   endfunction

   // Checks, position tracking and loopback drive for one falling edge
   task automatic pixel_cycle();
      logic               hs_fall;
      logic               hs_rise;
      logic               vs_fall;
      logic               vs_rise;
      logic [11:0]        exp_col;
      vga_pkg::vga_pins_t drive;
      hs_fall = hs_prev & ~pins.hsync;
      hs_rise = ~hs_prev & pins.hsync;
      vs_fall = vs_prev & ~pins.vsync;
      vs_rise = ~vs_prev & pins.vsync;
      cycles++;
      if (cycles > limit) begin
         report_error("timeout, trace frames did not complete in time");
      end
      assert (!err_live || err == exp_err) else report_mismatch("err", 32'(err), 32'(exp_err));
      assert (locked == exp_locked) else report_mismatch("locked", 32'(locked), 32'(exp_locked));
      assert (frame_count == exp_fc) else
         report_mismatch("frame_count", 32'(frame_count), 32'(exp_fc));
      // Idle pins until the first line starts
      if (!h_seen && !hs_fall) begin
         assert (pins == 14'h0003) else report_mismatch("pins", 32'(pins), 32'h0003);
      end
      if (hs_fall) begin
         if (h_seen) begin
            assert (h_idx == H_TOT - 1) else report_mismatch("hsync period", h_idx + 1, H_TOT);
         end
         h_seen = 1'b1;
         h_idx  = 0;
         h_low  = 0;
         if (vs_fall) begin
            if (v_seen) begin
               assert (v_idx == V_TOT - 1) else
                  report_mismatch("vsync period", v_idx + 1, V_TOT);
            end
            v_seen = 1'b1;
            v_idx  = 0;
         end else begin
            v_idx++;
         end
      end else begin
         h_idx++;
      end
      if (!pins.hsync) begin
         h_low++;
      end
      if (hs_rise) begin
         assert (h_low == H_PW) else report_mismatch("hsync width", h_low, H_PW);
      end
      // vsync edges only at line starts
      assert (!((vs_fall || vs_rise) && !hs_fall)) else
         report_error("vsync changed away from an hsync falling edge");
      if (vs_rise) begin
         assert (v_idx == V_PW) else report_mismatch("vsync width", v_idx, V_PW);
      end
      // Black outside the visible rectangle
      if (v_seen) begin
         exp_col = 12'h000;
         if (h_idx >= H_PW + H_BP && h_idx < H_PW + H_BP + H_VIS &&
             v_idx >= V_PW + V_BP && v_idx < V_PW + V_BP + V_VIS) begin
            exp_col = expected_colour(h_idx - H_PW - H_BP, v_idx - V_PW - V_BP);
         end
         assert (pins.colour == exp_col) else
            report_mismatch("pins.colour", 32'(pins.colour), 32'(exp_col));
      end
      drive = pins;
      // Early hsync fall except before lines that carry a vsync edge
      if (fault == 1 && h_idx == H_TOT - 1 && v_idx != 1 && v_idx != V_TOT - 1) begin
         drive.hsync = 1'b0;
      end
      // One lit pixel at the first front-porch count
      if (fault == 2 && frames_seen == 0 && v_idx == 5 && h_idx == H_PW + H_BP + H_VIS) begin
         drive.colour = 12'h5a5;
      end
      // vsync back high after one line
      if (fault == 3 && frames_seen == 0 && v_idx == 1) begin
         drive.vsync = 1'b1;
      end
      if (mon_vs_prev && !drive.vsync) begin
         if (exp_locked) begin
            exp_fc++;
         end
         exp_locked = 1'b1;
      end
      mon_vs_prev = drive.vsync;
      mon         = drive;
      if (vs_fall) begin
         frames_seen++;
      end
      hs_prev = pins.hsync;
      vs_prev = pins.vsync;
      if (fault == 0 && ($random(seed) % 50) == 0) begin
         solid = 12'($random(seed));
      end
   endtask

   initial begin
      int    fd;
      int    code;
      int    total;
      int    s;
      string line;
      seed        = 32'ha3da_9104;
      clk         = 1'b0;
      rst_n       = 1'b0;
      pattern     = vga_pkg::pat_solid;
      solid       = '0;
      mon         = 14'h0003;
      clear       = 1'b0;
      h_idx       = 0;
      v_idx       = 0;
      h_low       = 0;
      h_seen      = 1'b0;
      v_seen      = 1'b0;
      hs_prev     = 1'b1;
      vs_prev     = 1'b1;
      mon_vs_prev = 1'b1;
      fault       = 0;
      frames_seen = 0;
      err_live    = 1'b1;
      exp_err     = '0;
      exp_locked  = 1'b0;
      exp_fc      = '0;
      cycles      = 0;
      n_steps     = 0;
      total       = 0;
      fd = $fopen("tests/vga_trace.txt", "r");
      if (fd == 0) begin
         report_error("cannot open tests/vga_trace.txt");
      end
      while (!$feof(fd) && n_steps < MAX_STEPS) begin
         code = $fgets(line, fd);
         if (code > 0 && line.len() > 1 && line[0] != "#") begin
            code = $sscanf(line, "%h %h %d %d %h %d", st_pattern[n_steps],
                           st_solid[n_steps], st_fault[n_steps], st_frames[n_steps],
                           st_err[n_steps], st_clear[n_steps]);
            if (code != 6) begin
               report_error("malformed line in tests/vga_trace.txt");
            end
            total += st_frames[n_steps];
            n_steps++;
         end
      end
      $fclose(fd);
      limit = total * H_TOT * V_TOT * 2 + 200;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (s = 0; s < n_steps; s++) begin
         pattern     = vga_pkg::pattern_t'(2'(st_pattern[s]));
         solid       = 12'(st_solid[s]);
         fault       = st_fault[s];
         exp_err     = 5'(st_err[s]);
         err_live    = (fault == 0);
         frames_seen = 0;
         while (frames_seen < st_frames[s]) begin
            @(negedge clk);
            pixel_cycle();
         end
         // Let late flags settle before the step result
         fault    = 0;
         err_live = 1'b0;
         repeat (4) begin
            @(negedge clk);
            pixel_cycle();
         end
         assert (err == exp_err) else report_mismatch("err", 32'(err), 32'(exp_err));
         if (st_clear[s] != 0) begin
            clear    = 1'b1;
            exp_err  = '0;
            err_live = 1'b1;
            @(negedge clk);
            pixel_cycle();
            clear = 1'b0;
         end
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* tests/vga_trace.txt */
# pattern(hex) solid(hex) fault frames exp_err(hex) clear
# fault 0 clean, 1 early hsync, 2 porch colour, 3 short vsync; err bits hs_w hs_p vs_w vs_p blank
0 5a3 0 2 00 0
1 000 0 1 00 0
2 000 0 1 00 0
3 000 0 1 00 0
0 000 1 1 18 1
0 f0f 0 1 00 0
1 000 2 1 01 1
2 000 0 1 00 0
2 000 3 1 04 1
3 000 0 1 00 0
0 000 1 2 18 1
0 7c1 0 2 00 0
3 000 2 2 01 1
1 000 0 1 00 0
0 000 3 1 04 1
0 0f0 0 1 00 0
2 000 0 2 00 0
